//--- source/dcache_data_consts.svh
// Width constants for the ECC protected data bank of the data cache.
`ifndef DCACHE_DATA_CONSTS_SVH
`define DCACHE_DATA_CONSTS_SVH

// data word width.
`define DCACHE_DATA_DW 32

// six Hamming check bits plus one overall parity bit.
`define DCACHE_CHECK_W 7

// full SECDED codeword as stored in the RAM.
`define DCACHE_CODE_W 39

// the default address width gives 512 words.
`define DCACHE_DATA_AW 9

// width of each saturating ECC event counter.
`define DCACHE_ECC_CNT_W 8

`endif

//--- source/dcache_data_pkg.sv
// Types of the ECC data bank for the codeword views and the request and response words.
`include "dcache_data_consts.svh"

package dcache_data_pkg;

	// check[5:0] holds the Hamming bit for position 2**i and check[6] the overall parity.
	typedef struct packed {
		logic [`DCACHE_CHECK_W-1:0] check;
		logic [`DCACHE_DATA_DW-1:0] data;
	} dcache_code_fields_t;

	// the RAM sees a plain vector while the ECC logic works on the fields.
	typedef union packed {
		logic [`DCACHE_CODE_W-1:0] raw;
		dcache_code_fields_t       f;
	} dcache_code_t;

	typedef struct packed {
		logic                       cs;
		logic                       we;
		logic [`DCACHE_DATA_AW-1:0] addr;
		logic [`DCACHE_DATA_DW-1:0] wdata;
		// error injection mask that is applied to the raw codeword on writes.
		logic [`DCACHE_CODE_W-1:0]  inject;
	} dcache_req_t;

	typedef struct packed {
		logic                       valid;
		logic [`DCACHE_DATA_DW-1:0] rdata;
		logic                       err_corr;
		logic                       err_uncorr;
	} dcache_rsp_t;

endpackage

//--- source/dcache_ecc_encode.sv
// SECDED encoder that turns a 32-bit data word into a 39-bit Hamming codeword.
`include "dcache_data_consts.svh"

module dcache_ecc_encode
	import dcache_data_pkg::*;
(
	input  logic [`DCACHE_DATA_DW-1:0] data,
	output dcache_code_t               code
);

	localparam int HAM_W = `DCACHE_CHECK_W - 1;
	localparam int NPOS  = `DCACHE_CODE_W - 1;

	// Hamming positions 1 to NPOS with the check positions left at zero.
	logic [NPOS:1]    pos;
	logic [HAM_W-1:0] ham;

	// data bits fill the positions that are not powers of two, in ascending order.
	always_comb begin : place_data
		int d;
		d = 0;
		pos = '0;
		for (int p = 1; p <= NPOS; p++) begin
			if ((p & (p - 1)) != 0) begin
				pos[p] = data[d];
				d++;
			end
		end
	end

	// check bit i covers every position whose index has bit i set.
	always_comb begin : hamming_checks
		ham = '0;
		for (int i = 0; i < HAM_W; i++) begin
			for (int p = 1; p <= NPOS; p++) begin
				if (((p >> i) & 1) != 0) begin
					ham[i] = ham[i] ^ pos[p];
				end
			end
		end
	end

	// the top check bit makes the whole codeword even.
	always_comb begin : assemble
		code.f.data  = data;
		code.f.check = {^{ham, data}, ham};
	end

endmodule

//--- source/dcache_ecc_decode.sv
// SECDED decoder that corrects single-bit errors and flags double-bit errors.
`include "dcache_data_consts.svh"

module dcache_ecc_decode
	import dcache_data_pkg::*;
(
	input  dcache_code_t               code,
	output logic [`DCACHE_DATA_DW-1:0] data,
	output logic                       err_corr,
	output logic                       err_uncorr
);

	localparam int HAM_W = `DCACHE_CHECK_W - 1;
	localparam int NPOS  = `DCACHE_CODE_W - 1;

	logic [NPOS:1]    pos;
	logic [NPOS:1]    fixed;
	logic [HAM_W-1:0] syndrome;
	logic             parity_odd;
	logic             syn_nonzero;

	// rebuild the Hamming ordered word from the stored fields.
	always_comb begin : unpack
		int d;
		int c;
		d = 0;
		c = 0;
		pos = '0;
		for (int p = 1; p <= NPOS; p++) begin
			if ((p & (p - 1)) == 0) begin
				// powers of two come in ascending order, so c tracks log2 of p.
				pos[p] = code.f.check[c];
				c++;
			end else begin
				pos[p] = code.f.data[d];
				d++;
			end
		end
	end

	// each syndrome bit recomputes one Hamming check including the stored check bit.
	always_comb begin : syndrome_calc
		syndrome = '0;
		for (int i = 0; i < HAM_W; i++) begin
			for (int p = 1; p <= NPOS; p++) begin
				if (((p >> i) & 1) != 0) begin
					syndrome[i] = syndrome[i] ^ pos[p];
				end
			end
		end
	end

	assign parity_odd  = ^code.raw;
	assign syn_nonzero = |syndrome;

	// odd parity means one flipped bit, located by the syndrome.
	// A zero syndrome points at the parity bit itself, which carries no data.
	always_comb begin : correct
		fixed = pos;
		if (parity_odd && syn_nonzero && (syndrome <= NPOS)) begin
			fixed[syndrome] = ~pos[syndrome];
		end
	end

	// a double error leaves fixed equal to pos, so the data passes through as stored.
	always_comb begin : extract
		int d;
		d = 0;
		data = '0;
		for (int p = 1; p <= NPOS; p++) begin
			if ((p & (p - 1)) != 0) begin
				data[d] = fixed[p];
				d++;
			end
		end
	end

	assign err_corr   = parity_odd;
	assign err_uncorr = ~parity_odd & syn_nonzero;

endmodule

//--- source/dcache_data_ecc_ram.sv
// Single-port synchronous RAM that stores the ECC codewords of the data bank.
`include "dcache_data_consts.svh"

module dcache_data_ecc_ram
	import dcache_data_pkg::*;
#(
	parameter int ADDR_W = `DCACHE_DATA_AW
) (
	input  logic              clk,
	input  logic              cs,
	input  logic              we,
	input  logic [ADDR_W-1:0] addr,
	input  dcache_code_t      wdata,
	output dcache_code_t      rdata
);

	localparam int DEPTH = 2 ** ADDR_W;

	logic [`DCACHE_CODE_W-1:0] mem [DEPTH];
	logic [`DCACHE_CODE_W-1:0] rd_word;

	// the write port is active when the bank is selected with write enable.
	always_ff @(posedge clk) begin
		if (cs && we) begin
			mem[addr] <= wdata.raw;
		end
	end

	// the read word is registered and holds while the RAM is idle or writing.
	always_ff @(posedge clk) begin
		if (cs && !we) begin
			rd_word <= mem[addr];
		end
	end

	assign rdata.raw = rd_word;

endmodule

//--- source/dcache_data_bank.sv
// ECC protected data bank of the data cache with error injection and event counters.
`include "dcache_data_consts.svh"

module dcache_data_bank
	import dcache_data_pkg::*;
(
	input  logic                         clk,
	input  logic                         arst_n,
	input  dcache_req_t                  req,
	output dcache_rsp_t                  rsp,
	output logic [`DCACHE_ECC_CNT_W-1:0] corr_count,
	output logic [`DCACHE_ECC_CNT_W-1:0] uncorr_count
);

	dcache_code_t               enc_code;
	dcache_code_t               wr_code;
	dcache_code_t               rd_code;
	logic [`DCACHE_DATA_DW-1:0] dec_data;
	logic                       dec_corr;
	logic                       dec_uncorr;
	logic                       rd_pend;

	// counter step that sticks at all ones.
	function automatic logic [`DCACHE_ECC_CNT_W-1:0] sat_inc(
		input logic [`DCACHE_ECC_CNT_W-1:0] value
	);
		if (&value) begin
			return value;
		end
		return value + 1'b1;
	endfunction

	dcache_ecc_encode u_encode (
		.data (req.wdata),
		.code (enc_code)
	);

	// the injection mask lets a test corrupt chosen bits of the stored word.
	assign wr_code.raw = enc_code.raw ^ req.inject;

	dcache_data_ecc_ram #(
		.ADDR_W (`DCACHE_DATA_AW)
	) u_ram (
		.clk   (clk),
		.cs    (req.cs),
		.we    (req.we),
		.addr  (req.addr),
		.wdata (wr_code),
		.rdata (rd_code)
	);

	dcache_ecc_decode u_decode (
		.code       (rd_code),
		.data       (dec_data),
		.err_corr   (dec_corr),
		.err_uncorr (dec_uncorr)
	);

	// the RAM returns a read one cycle after the request edge.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= req.cs & ~req.we;
		end
	end

	always_comb begin
		rsp.valid      = rd_pend;
		rsp.rdata      = dec_data;
		rsp.err_corr   = rd_pend & dec_corr;
		rsp.err_uncorr = rd_pend & dec_uncorr;
	end

	// counts are taken at the edge that closes the valid cycle.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			corr_count   <= '0;
			uncorr_count <= '0;
		end else begin
			if (rsp.err_corr) begin
				corr_count <= sat_inc(corr_count);
			end
			if (rsp.err_uncorr) begin
				uncorr_count <= sat_inc(uncorr_count);
			end
		end
	end

endmodule

//--- verification/dcache_data_bank_tb.sv
// Testbench for the ECC data bank that runs a stimulus table with injected bit errors.
`include "dcache_data_consts.svh"

module dcache_data_bank_tb
	import dcache_data_pkg::*;
;

	// one row of the stimulus table; idle rows have cs low.
	typedef struct packed {
		logic                       cs;
		logic                       we;
		logic [`DCACHE_DATA_AW-1:0] addr;
		logic [`DCACHE_DATA_DW-1:0] wdata;
		logic [`DCACHE_CODE_W-1:0]  inject;
		dcache_rsp_t                exp;
	} entry_t;

	logic                         clk;
	logic                         arst_n;
	dcache_req_t                  req;
	dcache_rsp_t                  rsp;
	logic [`DCACHE_ECC_CNT_W-1:0] corr_count;
	logic [`DCACHE_ECC_CNT_W-1:0] uncorr_count;

	entry_t                     stim [$];
	string                      names [$];
	logic [`DCACHE_DATA_DW-1:0] data_model [2**`DCACHE_DATA_AW];
	logic [`DCACHE_CODE_W-1:0]  inject_model [2**`DCACHE_DATA_AW];
	logic [31:0]                lfsr_state = 32'd77151;
	int                         exp_corr_total = 0;
	int                         exp_uncorr_total = 0;
	int                         pass_count = 0;
	int                         fail_count = 0;
	int                         cycles = 0;
	int                         cycle_limit = 1000;

	dcache_data_bank dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.req          (req),
		.rsp          (rsp),
		.corr_count   (corr_count),
		.uncorr_count (uncorr_count)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Galois form of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic draw_word(output logic [`DCACHE_DATA_DW-1:0] w);
		w = '0;
		for (int b = 0; b < `DCACHE_DATA_DW; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[`DCACHE_DATA_DW-2:0], lfsr_state[0]};
		end
	endtask

	task automatic add_idle(input string name);
		entry_t e;
		e = '0;
		stim.push_back(e);
		names.push_back(name);
	endtask

	task automatic add_write(input string name, input logic [`DCACHE_DATA_AW-1:0] addr,
		input logic [`DCACHE_CODE_W-1:0] inj);
		entry_t e;
		logic [`DCACHE_DATA_DW-1:0] w;
		draw_word(w);
		e = '0;
		e.cs = 1'b1;
		e.we = 1'b1;
		e.addr = addr;
		e.wdata = w;
		e.inject = inj;
		data_model[addr] = w;
		inject_model[addr] = inj;
		stim.push_back(e);
		names.push_back(name);
	endtask

	// one flipped bit is corrected, two flipped bits leave the stored data field as is.
	task automatic add_read(input string name, input logic [`DCACHE_DATA_AW-1:0] addr);
		entry_t e;
		logic [`DCACHE_CODE_W-1:0] inj;
		inj = inject_model[addr];
		e = '0;
		e.cs = 1'b1;
		e.addr = addr;
		e.exp.valid = 1'b1;
		e.exp.rdata = data_model[addr];
		if ($countones(inj) == 1) begin
			e.exp.err_corr = 1'b1;
			exp_corr_total++;
		end else if ($countones(inj) == 2) begin
			e.exp.err_uncorr = 1'b1;
			e.exp.rdata = data_model[addr] ^ inj[`DCACHE_DATA_DW-1:0];
			exp_uncorr_total++;
		end
		stim.push_back(e);
		names.push_back(name);
	endtask

	// rdata is only meaningful in a valid cycle.
	task automatic check_rsp(input string name, input dcache_rsp_t exp, input dcache_rsp_t act);
		dcache_rsp_t seen;
		seen = act;
		if (!exp.valid) begin
			seen.rdata = exp.rdata;
		end
		if (seen !== exp) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			fail_count++;
		end else begin
			$display("Pass %s", name);
			pass_count++;
		end
	endtask

	task automatic check_count(input string name, input logic [`DCACHE_ECC_CNT_W-1:0] exp,
		input logic [`DCACHE_ECC_CNT_W-1:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %0d actual %0d", name, exp, act);
			fail_count++;
		end else begin
			$display("Pass %s", name);
			pass_count++;
		end
	endtask

	task automatic drive_entry(input entry_t e);
		req.cs = e.cs;
		req.we = e.we;
		req.addr = e.addr;
		req.wdata = e.wdata;
		req.inject = e.inject;
	endtask

	task automatic build_table();
		add_idle("idle_after_reset");
		add_write("write_clean", 9'd3, '0);
		add_read("read_clean", 9'd3);
		add_idle("valid_one_cycle");
		add_write("write_data_bit5", 9'd17, 39'd1 << 5);
		add_read("read_data_bit5", 9'd17);
		add_write("write_data_bit31", 9'd100, 39'd1 << 31);
		add_read("read_data_bit31", 9'd100);
		add_write("write_check_bit0", 9'd200, 39'd1 << 32);
		add_read("read_check_bit0", 9'd200);
		add_write("write_check_bit5", 9'd201, 39'd1 << 37);
		add_read("read_check_bit5", 9'd201);
		add_write("write_parity_bit", 9'd202, 39'd1 << 38);
		add_read("read_parity_bit", 9'd202);
		add_idle("idle_cs_low");
		add_write("write_double_data", 9'd300, (39'd1 << 9) | 39'd1);
		add_read("read_double_data", 9'd300);
		add_write("write_double_mixed", 9'd301, (39'd1 << 33) | (39'd1 << 2));
		add_read("read_double_mixed", 9'd301);
		add_write("write_top_addr", 9'd511, '0);
		add_read("read_top_addr", 9'd511);
		add_read("read_back_to_back", 9'd3);
		add_idle("idle_end");
	endtask

	// the run is bounded by the table length, the reset and a margin.
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		int last;
		arst_n = 1'b0;
		req = '0;
		build_table();
		last = stim.size() - 1;
		cycle_limit = 2 * stim.size() + 16 + 50;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		check_count("corr_count_after_reset", '0, corr_count);
		check_count("uncorr_count_after_reset", '0, uncorr_count);
		for (int i = 0; i < stim.size(); i++) begin
			@(negedge clk);
			if (i > 0) begin
				check_rsp(names[i-1], stim[i-1].exp, rsp);
			end
			drive_entry(stim[i]);
		end
		@(negedge clk);
		check_rsp(names[last], stim[last].exp, rsp);
		req = '0;
		repeat (2) @(negedge clk);
		check_count("corr_count_final", exp_corr_total[`DCACHE_ECC_CNT_W-1:0], corr_count);
		check_count("uncorr_count_final", exp_uncorr_total[`DCACHE_ECC_CNT_W-1:0], uncorr_count);
		$display("%0d checks passed, %0d checks failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- dcache_data_bank.f
+incdir+source
source/dcache_data_pkg.sv
source/dcache_ecc_encode.sv
source/dcache_ecc_decode.sv
source/dcache_data_ecc_ram.sv
source/dcache_data_bank.sv
verification/dcache_data_bank_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary
TOP       := dcache_data_bank_tb
FLIST     := dcache_data_bank.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
